// ==== mold_parser.f ====
+incdir+verif
source/mold_proto_pkg.sv
source/mold_stream_pkg.sv
source/mold_skid_buffer.sv
source/mold_byte_buffer.sv
source/mold_frame_parser.sv
source/mold_parser.sv
verif/mold_parser_properties.sv
verif/mold_parser_tb.sv

// ==== Makefile ====
# Verilator build and run of the mold_parser testbench

VERILATOR ?= verilator
TOP       ?= mold_parser_tb
FLIST     ?= mold_parser.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o $(TOP)

# the run fails unless the simulation prints the pass line
run: compile
	@out="$$($(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/mold_parser_tests.svh ====
// directed tests, included inside mold_parser_tb; each one leaves the DUT idle and queues empty
`ifndef MOLD_PARSER_TESTS_SVH
`define MOLD_PARSER_TESTS_SVH
`default_nettype none

// input open and both outputs idle once reset is released
task automatic test_reset_state();
	compare_val("reset_state", "axis_tready_o", 80'(1'b1), 80'(axis_tready_o));
	compare_val("reset_state", "mold_msg_v_o", 80'(1'b0), 80'(mold_msg_v_o));
	compare_val("reset_state", "eos_v_o", 80'(1'b0), 80'(eos_v_o));
endtask

// one short message fits a single beat
task automatic test_single();
	build_packet(80'h0102_0304_0506_0708_090A, 64'd1000, 16'd1, '{5, 0, 0, 0}, 0);
	run_check("single", 1'b0);
endtask

// length fields land at unaligned offsets 20, 35 and 45
task automatic test_multi();
	build_packet(80'hA1A2_A3A4_A5A6_A7A8_A9AA, 64'h0000_0001_0000_0000, 16'd3,
		'{13, 8, 1, 0}, 0);
	run_check("multi", 1'b0);
endtask

// empty message emits nothing but still takes a sequence number
task automatic test_zero_len();
	build_packet(80'h1111_2222_3333_4444_5555, 64'd500, 16'd3, '{4, 0, 9, 0}, 0);
	run_check("zero_len", 1'b0);
endtask

task automatic test_eos();
	build_packet(80'hEEEE_0000_1111_2222_3333, 64'd77, 16'hFFFF, '{0, 0, 0, 0}, 0);
	build_packet(80'hEEEE_0000_1111_2222_3333, 64'd78, 16'd2, '{3, 16, 0, 0}, 0);
	run_check("eos", 1'b0);
endtask

// random ready and input gaps, no end of session here
task automatic test_backpressure();
	build_packet(80'h5A5A_5A5A_5A5A_5A5A_5A5A, 64'd9000, 16'd3, '{13, 8, 1, 0}, 0);
	build_packet(80'h5A5A_5A5A_5A5A_5A5A_5A5A, 64'd9003, 16'd4, '{20, 0, 7, 2}, 3);
	run_check("backpressure", 1'b1);
endtask

// padding after the last message, then a second packet right behind it
task automatic test_trailing();
	build_packet(80'hC0C1_C2C3_C4C5_C6C7_C8C9, 64'd40, 16'd2, '{6, 11, 0, 0}, 5);
	build_packet(80'hD0D1_D2D3_D4D5_D6D7_D8D9, 64'd60, 16'd1, '{9, 0, 0, 0}, 0);
	run_check("trailing", 1'b0);
endtask

`default_nettype wire
`endif

// ==== verif/mold_parser_tb.sv ====
// directed testbench for mold_parser; packets are always sent whole and tkeep is contiguous
`default_nettype none
`timescale 1ns/1ps

module mold_parser_tb;

	localparam int MAX_CYCLES = 20000;

	logic                       clk = 1'b0;
	logic                       nreset;
	logic                       axis_tvalid_i;
	logic [63:0]                axis_tdata_i;
	logic [7:0]                 axis_tkeep_i;
	logic                       axis_tlast_i;
	logic                       axis_tready_o;
	logic                       mold_msg_v_o;
	mold_stream_pkg::msg_beat_t mold_msg_o;
	logic                       mold_msg_ready_i;
	logic                       eos_v_o;

	int seed = 52355;
	int errors = 0;
	int checked = 0;
	int cycles = 0;
	int eos_cnt = 0;
	int exp_eos = 0;
	int ready_rnd;
	bit stall_en = 1'b0;
	mold_stream_pkg::axis_beat_t in_q[$];
	mold_stream_pkg::msg_beat_t  exp_q[$];
	mold_stream_pkg::msg_beat_t  got_q[$];

	mold_parser #(.BUF_BYTES(16)) u_mold_parser (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: no progress after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// random back-pressure only while a stall test runs
	always @(posedge clk) begin
		#1;
		ready_rnd = $random(seed);
		mold_msg_ready_i = stall_en ? ready_rnd[0] : 1'b1;
	end

	// ready is driven after the edge, so negedge sees the values of the next handshake
	always @(negedge clk) begin
		if (nreset && mold_msg_v_o && mold_msg_ready_i) begin
			got_q.push_back(mold_msg_o);
		end
		if (nreset && eos_v_o) begin
			eos_cnt++;
		end
	end

	// header, length-prefixed messages and trailing bytes, plus the beats they must produce
	task automatic build_packet(input mold_proto_pkg::sid_t sid, input mold_proto_pkg::seq_t seq,
		input mold_proto_pkg::msg_len_t cnt, input int lens[4], input int trail);
		logic [7:0] pkt[$];
		mold_stream_pkg::msg_beat_t e;
		mold_stream_pkg::axis_beat_t b;
		logic [15:0] len;
		int nmsg;
		int r;
		for (int i = 9; i >= 0; i--) pkt.push_back(sid[8*i +: 8]);
		for (int i = 7; i >= 0; i--) pkt.push_back(seq[8*i +: 8]);
		pkt.push_back(cnt[15:8]);
		pkt.push_back(cnt[7:0]);
		nmsg = (cnt == 16'hFFFF) ? 0 : int'(cnt);
		if (cnt == 16'hFFFF) exp_eos++;
		for (int k = 0; k < nmsg; k++) begin
			len = 16'(lens[k]);
			pkt.push_back(len[15:8]);
			pkt.push_back(len[7:0]);
			for (int i = 0; i < int'(len); i++) begin
				if (i % 8 == 0) begin
					e = '0;
					e.start = (i == 0);
					e.sid = sid;
					e.seq = seq + 64'(k);
				end
				r = $random(seed);
				pkt.push_back(r[7:0]);
				e.data[8*(i%8) +: 8] = r[7:0];
				e.mask[i%8] = 1'b1;
				if (i % 8 == 7 || i == int'(len) - 1) begin
					e.last = (i == int'(len) - 1);
					exp_q.push_back(e);
				end
			end
		end
		for (int i = 0; i < trail; i++) begin
			r = $random(seed);
			pkt.push_back(r[7:0]);
		end
		for (int i = 0; i < pkt.size(); i += 8) begin
			b = '0;
			for (int j = 0; j < 8 && i + j < pkt.size(); j++) begin
				b.data[8*j +: 8] = pkt[i+j];
				b.keep[j] = 1'b1;
			end
			b.last = (i + 8 >= pkt.size());
			in_q.push_back(b);
		end
	endtask

	task automatic send_beats(input bit gaps);
		mold_stream_pkg::axis_beat_t b;
		logic ok;
		int r;
		while (in_q.size() > 0) begin
			r = $random(seed);
			if (gaps && r[1:0] == 2'b00) begin
				axis_tvalid_i = 1'b0;
				@(posedge clk);
				#1;
			end else begin
				b = in_q.pop_front();
				axis_tvalid_i = 1'b1;
				axis_tdata_i = b.data;
				axis_tkeep_i = b.keep;
				axis_tlast_i = b.last;
				ok = 1'b0;
				while (!ok) begin
					@(negedge clk);
					ok = axis_tready_o;
					@(posedge clk);
					#1;
				end
			end
		end
		axis_tvalid_i = 1'b0;
	endtask

	task automatic compare_val(input string name, input string what, input logic [79:0] expv,
		input logic [79:0] actv);
		if (expv !== actv) begin
			errors++;
			$display("Fail %s %s: expected %0h, actual %0h", name, what, expv, actv);
		end
	endtask

	task automatic run_check(input string name, input bit stalls);
		string lbl;
		int n;
		stall_en = stalls;
		send_beats(stalls);
		while (got_q.size() < exp_q.size() || eos_cnt < exp_eos) @(posedge clk);
		// idle time lets any extra or duplicated beat show up
		stall_en = 1'b0;
		repeat (30) @(posedge clk);
		#1;
		compare_val(name, "beat count", 80'(exp_q.size()), 80'(got_q.size()));
		compare_val(name, "eos pulses", 80'(exp_eos), 80'(eos_cnt));
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			lbl = $sformatf("beat %0d", i);
			compare_val(name, {lbl, " data"}, 80'(exp_q[i].data), 80'(got_q[i].data));
			compare_val(name, {lbl, " mask"}, 80'(exp_q[i].mask), 80'(got_q[i].mask));
			compare_val(name, {lbl, " start"}, 80'(exp_q[i].start), 80'(got_q[i].start));
			compare_val(name, {lbl, " last"}, 80'(exp_q[i].last), 80'(got_q[i].last));
			compare_val(name, {lbl, " sid"}, exp_q[i].sid, got_q[i].sid);
			compare_val(name, {lbl, " seq"}, 80'(exp_q[i].seq), 80'(got_q[i].seq));
			checked++;
		end
		exp_q.delete();
		got_q.delete();
		eos_cnt = 0;
		exp_eos = 0;
	endtask

	initial begin
		nreset = 1'b0;
		axis_tvalid_i = 1'b0;
		axis_tdata_i = '0;
		axis_tkeep_i = '0;
		axis_tlast_i = 1'b0;
		mold_msg_ready_i = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		nreset = 1'b1;
		test_reset_state();
		test_single();
		test_multi();
		test_zero_len();
		test_eos();
		test_backpressure();
		test_trailing();
		errors += u_mold_parser.u_properties.fail_cnt;
		$display("Summary: %0d errors, %0d beats checked", errors, checked);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

`include "mold_parser_tests.svh"

endmodule

`default_nettype wire

// ==== verif/mold_parser_properties.sv ====
// port checks for mold_parser; only active when the simulator evaluates concurrent assertions
`default_nettype none
`timescale 1ns/1ps

module mold_parser_properties (
	input logic                       clk,
	input logic                       nreset,
	input logic                       axis_tvalid_i,
	input logic [63:0]                axis_tdata_i,
	input logic [7:0]                 axis_tkeep_i,
	input logic                       axis_tlast_i,
	input logic                       axis_tready_o,
	input logic                       mold_msg_v_o,
	input mold_stream_pkg::msg_beat_t mold_msg_o,
	input logic                       mold_msg_ready_i,
	input logic                       eos_v_o
);

	// high between a message's first and last transferred beat
	logic in_msg_q;

	// failed assertion count
	int fail_cnt = 0;

	always_ff @(posedge clk) begin
		if (~nreset) begin
			in_msg_q <= 1'b0;
		end else if (mold_msg_v_o && mold_msg_ready_i) begin
			in_msg_q <= ~mold_msg_o.last;
		end
	end

	out_stable: assert property (@(posedge clk) disable iff (~nreset)
		mold_msg_v_o && !mold_msg_ready_i |=> mold_msg_v_o && $stable(mold_msg_o))
		else begin
			$error("message beat changed while stalled");
			fail_cnt++;
		end

	in_stable: assert property (@(posedge clk) disable iff (~nreset)
		axis_tvalid_i && !axis_tready_o |=> axis_tvalid_i
			&& $stable({axis_tdata_i, axis_tkeep_i, axis_tlast_i}))
		else begin
			$error("input beat changed while stalled");
			fail_cnt++;
		end

	start_first: assert property (@(posedge clk) disable iff (~nreset)
		mold_msg_v_o && mold_msg_o.start |-> !in_msg_q)
		else begin
			$error("start flag inside a message");
			fail_cnt++;
		end

	eos_no_start: assert property (@(posedge clk) disable iff (~nreset)
		!(eos_v_o && mold_msg_v_o && mold_msg_o.start))
		else begin
			$error("end of session together with a message start");
			fail_cnt++;
		end

endmodule

bind mold_parser mold_parser_properties u_properties (.*);

`default_nettype wire

// ==== source/mold_parser.sv ====
// moldudp64 parser top; BUF_BYTES must be at least 16 and tkeep contiguous from lane 0
`default_nettype none
`timescale 1ns/1ps

module mold_parser #(
	parameter int BUF_BYTES = 16
) (
	input  logic                                  clk,
	input  logic                                  nreset,

	// udp payload stream
	input  logic                                  axis_tvalid_i,
	input  logic [mold_stream_pkg::BEAT_BYTES*8-1:0] axis_tdata_i,
	input  logic [mold_stream_pkg::BEAT_BYTES-1:0]   axis_tkeep_i,
	input  logic                                  axis_tlast_i,
	output logic                                  axis_tready_o,

	// message beats
	output logic                                  mold_msg_v_o,
	output mold_stream_pkg::msg_beat_t            mold_msg_o,
	input  logic                                  mold_msg_ready_i,

	output logic                                  eos_v_o
);

	mold_stream_pkg::axis_beat_t in_beat;
	mold_stream_pkg::axis_beat_t ing_beat;
	logic                        ing_v;
	logic                        ing_ready;

	logic [mold_stream_pkg::BEAT_BYTES-1:0][7:0] win_data;
	mold_stream_pkg::byte_cnt_t  win_cnt;
	mold_stream_pkg::byte_cnt_t  pop;
	logic                        win_eop;
	logic                        flush;

	mold_stream_pkg::msg_beat_t  msg;
	logic                        msg_v;
	logic                        msg_ready;

	assign in_beat = '{data: axis_tdata_i, keep: axis_tkeep_i, last: axis_tlast_i};

	mold_skid_buffer #(.payload_t(mold_stream_pkg::axis_beat_t)) u_ingress (
		.clk        (clk),
		.nreset     (nreset),
		.in_v_i     (axis_tvalid_i),
		.in_data_i  (in_beat),
		.in_ready_o (axis_tready_o),
		.out_v_o    (ing_v),
		.out_data_o (ing_beat),
		.out_ready_i(ing_ready)
	);

	mold_byte_buffer #(.BUF_BYTES(BUF_BYTES)) u_byte_buffer (
		.clk         (clk),
		.nreset      (nreset),
		.beat_v_i    (ing_v),
		.beat_i      (ing_beat),
		.beat_ready_o(ing_ready),
		.win_data_o  (win_data),
		.win_cnt_o   (win_cnt),
		.win_eop_o   (win_eop),
		.pop_i       (pop),
		.flush_i     (flush)
	);

	mold_frame_parser u_frame_parser (
		.clk        (clk),
		.nreset     (nreset),
		.win_data_i (win_data),
		.win_cnt_i  (win_cnt),
		.win_eop_i  (win_eop),
		.pop_o      (pop),
		.flush_o    (flush),
		.msg_v_o    (msg_v),
		.msg_o      (msg),
		.msg_ready_i(msg_ready),
		.eos_v_o    (eos_v_o)
	);

	// egress isolates the downstream ready from the framing logic
	mold_skid_buffer #(.payload_t(mold_stream_pkg::msg_beat_t)) u_egress (
		.clk        (clk),
		.nreset     (nreset),
		.in_v_i     (msg_v),
		.in_data_i  (msg),
		.in_ready_o (msg_ready),
		.out_v_o    (mold_msg_v_o),
		.out_data_o (mold_msg_o),
		.out_ready_i(mold_msg_ready_i)
	);

endmodule

`default_nettype wire

// ==== source/mold_frame_parser.sv ====
// moldudp64 framing FSM; packets cut short of their declared length are not recovered
`default_nettype none
`timescale 1ns/1ps

module mold_frame_parser (
	input  logic                                        clk,
	input  logic                                        nreset,

	input  logic [mold_stream_pkg::BEAT_BYTES-1:0][7:0] win_data_i,
	input  mold_stream_pkg::byte_cnt_t                  win_cnt_i,
	input  logic                                        win_eop_i,
	output mold_stream_pkg::byte_cnt_t                  pop_o,
	output logic                                        flush_o,

	output logic                                        msg_v_o,
	output mold_stream_pkg::msg_beat_t                  msg_o,
	input  logic                                        msg_ready_i,
	output logic                                        eos_v_o
);

	localparam int HB      = mold_proto_pkg::HDR_BYTES;
	localparam int BB      = mold_stream_pkg::BEAT_BYTES;
	localparam int HCW     = $clog2(HB + 1);
	localparam int SEQ_OFS = $bits(mold_proto_pkg::sid_t) / 8;
	localparam int CNT_OFS = SEQ_OFS + $bits(mold_proto_pkg::seq_t) / 8;

	typedef enum logic [1:0] {S_HDR, S_LEN, S_BODY, S_DRAIN} state_t;

	state_t                     state_q, state_d;
	logic [HCW-1:0]             hdr_cnt_q, hdr_left;
	logic [0:HB-1][7:0]         hdr_q, hdr_d;
	mold_proto_pkg::seq_t       seq_q;
	mold_proto_pkg::msg_len_t   cnt_q, hdr_msg_cnt, len_val, rem_q;
	logic                       len_got_q;
	logic [7:0]                 len_hi_q;
	logic                       first_q, eos_q;
	mold_stream_pkg::byte_cnt_t hdr_take, len_take, need;
	logic hdr_done, hdr_eos, len_done, fire, body_last, msg_done, pkt_done, eop_pop;

	// header bytes land at their offset in the 20 byte image
	assign hdr_left = HCW'(HB) - hdr_cnt_q;
	assign hdr_take = ({1'b0, win_cnt_i} < hdr_left) ? win_cnt_i
		: mold_stream_pkg::byte_cnt_t'(hdr_left);
	always_comb begin
		hdr_d = hdr_q;
		for (int j = 0; j < HB; j++) begin
			for (int i = 0; i < BB; i++) begin
				if (i < int'(hdr_take) && int'(hdr_cnt_q) + i == j) begin
					hdr_d[j] = win_data_i[i];
				end
			end
		end
	end
	assign hdr_done    = (state_q == S_HDR) && (hdr_cnt_q + HCW'(hdr_take) == HCW'(HB));
	assign hdr_msg_cnt = {hdr_d[CNT_OFS], hdr_d[CNT_OFS+1]};
	assign hdr_eos     = hdr_msg_cnt == mold_proto_pkg::EOS_MSG_CNT;

	// length field may straddle two windows
	assign len_take = len_got_q ? ((win_cnt_i != '0) ? 4'd1 : 4'd0)
		: ((win_cnt_i >= 4'd2) ? 4'd2 : win_cnt_i);
	assign len_done = (state_q == S_LEN) && (len_got_q ? (win_cnt_i != '0)
		: (win_cnt_i >= mold_stream_pkg::byte_cnt_t'(mold_proto_pkg::LEN_BYTES)));
	assign len_val  = len_got_q ? {len_hi_q, win_data_i[0]} : {win_data_i[0], win_data_i[1]};

	// body chunks are full beats except the tail of the message
	assign need = (rem_q >= mold_proto_pkg::msg_len_t'(BB))
		? mold_stream_pkg::byte_cnt_t'(BB) : mold_stream_pkg::byte_cnt_t'(rem_q);
	assign body_last = rem_q <= mold_proto_pkg::msg_len_t'(BB);
	assign msg_v_o   = (state_q == S_BODY) && (win_cnt_i >= need);
	assign fire      = msg_v_o & msg_ready_i;

	assign msg_done = (len_done && len_val == '0) || (fire && body_last);
	assign pkt_done = (hdr_done && (hdr_msg_cnt == '0 || hdr_eos)) || (msg_done && cnt_q == 16'd1);

	always_comb begin
		case (state_q)
			S_HDR:   pop_o = hdr_take;
			S_LEN:   pop_o = len_take;
			S_BODY:  pop_o = fire ? need : 4'd0;
			default: pop_o = 4'd0;
		endcase
	end
	assign flush_o = state_q == S_DRAIN;
	// this cycle consumes the packet's final byte, nothing left to drain
	assign eop_pop = win_eop_i && (pop_o == win_cnt_i) && (pop_o != '0);

	always_comb begin
		state_d = state_q;
		if (pkt_done) begin
			state_d = eop_pop ? S_HDR : S_DRAIN;
		end else if (hdr_done) begin
			state_d = S_LEN;
		end else if (len_done && len_val != '0) begin
			state_d = S_BODY;
		end else if (fire && body_last) begin
			state_d = S_LEN;
		end else if (state_q == S_DRAIN && win_eop_i) begin
			state_d = S_HDR;
		end
	end

	always_ff @(posedge clk) begin
		if (~nreset) begin
			state_q   <= S_HDR;
			hdr_cnt_q <= '0;
			len_got_q <= 1'b0;
			first_q   <= 1'b0;
			eos_q     <= 1'b0;
		end else begin
			state_q   <= state_d;
			eos_q     <= hdr_done & hdr_eos;
			if (hdr_done) begin
				hdr_cnt_q <= '0;
			end else if (state_q == S_HDR) begin
				hdr_cnt_q <= hdr_cnt_q + HCW'(hdr_take);
			end
			if (len_done) begin
				len_got_q <= 1'b0;
			end else if (state_q == S_LEN && win_cnt_i == 4'd1) begin
				len_got_q <= 1'b1;
			end
			if (len_done) begin
				first_q <= 1'b1;
			end else if (fire) begin
				first_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_HDR) begin
			hdr_q <= hdr_d;
		end
		if (state_q == S_LEN && ~len_got_q) begin
			len_hi_q <= win_data_i[0];
		end
		if (len_done) begin
			rem_q <= len_val;
		end else if (fire) begin
			rem_q <= rem_q - mold_proto_pkg::msg_len_t'(need);
		end
		// a zero-length message still consumes a sequence number
		if (hdr_done) begin
			seq_q <= hdr_d[SEQ_OFS:CNT_OFS-1];
			cnt_q <= hdr_msg_cnt;
		end else if (msg_done) begin
			seq_q <= seq_q + 64'd1;
			cnt_q <= cnt_q - 16'd1;
		end
	end

	always_comb begin
		logic lane_en;
		msg_o.start = first_q;
		msg_o.last  = body_last;
		msg_o.sid   = hdr_q[0:SEQ_OFS-1];
		msg_o.seq   = seq_q;
		for (int i = 0; i < BB; i++) begin
			lane_en              = i < int'(need);
			msg_o.mask[i]        = lane_en;
			msg_o.data[8*i +: 8] = lane_en ? win_data_i[i] : 8'h00;
		end
	end

	assign eos_v_o = eos_q;

endmodule

`default_nettype wire

// ==== source/mold_byte_buffer.sv ====
// byte window FIFO; the window never spans a packet boundary and pop must not exceed win_cnt_o
`default_nettype none
`timescale 1ns/1ps

module mold_byte_buffer #(
	parameter int BUF_BYTES = 16
) (
	input  logic                                      clk,
	input  logic                                      nreset,

	input  logic                                      beat_v_i,
	input  mold_stream_pkg::axis_beat_t               beat_i,
	output logic                                      beat_ready_o,

	output logic [mold_stream_pkg::BEAT_BYTES-1:0][7:0] win_data_o,
	output mold_stream_pkg::byte_cnt_t                win_cnt_o,
	output logic                                      win_eop_o,
	input  mold_stream_pkg::byte_cnt_t                pop_i,
	input  logic                                      flush_i
);

	localparam int CW = $clog2(BUF_BYTES + 1);
	localparam int BB = mold_stream_pkg::BEAT_BYTES;

	logic [7:0]           buf_q [BUF_BYTES];
	logic [7:0]           buf_d [BUF_BYTES];
	logic [BUF_BYTES-1:0] eop_q;
	logic [BUF_BYTES-1:0] eop_d;
	logic [CW-1:0]        cnt_q;
	logic [CW-1:0]        kept_cnt;
	mold_stream_pkg::byte_cnt_t beat_cnt;
	mold_stream_pkg::byte_cnt_t drop;
	logic                 accept;

	// window stops at the first end-of-packet marker
	always_comb begin
		win_eop_o = 1'b0;
		win_cnt_o = (cnt_q >= CW'(BB)) ? mold_stream_pkg::byte_cnt_t'(BB)
			: mold_stream_pkg::byte_cnt_t'(cnt_q);
		for (int i = 0; i < BB; i++) begin
			win_data_o[i] = buf_q[i];
			if (~win_eop_o && CW'(i) < cnt_q && eop_q[i]) begin
				win_eop_o = 1'b1;
				win_cnt_o = mold_stream_pkg::byte_cnt_t'(i + 1);
			end
		end
	end

	// keep is contiguous, so its popcount is the byte count
	always_comb begin
		beat_cnt = '0;
		for (int i = 0; i < BB; i++) begin
			beat_cnt = beat_cnt + mold_stream_pkg::byte_cnt_t'(beat_i.keep[i]);
		end
	end

	// flush drops the whole window, up to and including the marker if it shows
	assign drop     = flush_i ? win_cnt_o : pop_i;
	assign kept_cnt = cnt_q - CW'(drop);

	assign beat_ready_o = kept_cnt <= CW'(BUF_BYTES - BB);
	assign accept       = beat_v_i & beat_ready_o;

	always_comb begin
		int src;
		int lane;
		for (int j = 0; j < BUF_BYTES; j++) begin
			buf_d[j] = buf_q[j];
			eop_d[j] = eop_q[j];
			src      = j + int'(drop);
			lane     = j - int'(kept_cnt);
			if (src < BUF_BYTES) begin
				buf_d[j] = buf_q[src];
				eop_d[j] = eop_q[src];
			end
			// append the new beat right after the surviving bytes
			if (accept && lane >= 0 && lane < int'(beat_cnt)) begin
				buf_d[j] = beat_i.data[8*lane +: 8];
				eop_d[j] = beat_i.last && (lane == int'(beat_cnt) - 1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (~nreset) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= kept_cnt + (accept ? CW'(beat_cnt) : CW'(0));
		end
	end

	always_ff @(posedge clk) begin
		buf_q <= buf_d;
		eop_q <= eop_d;
	end

endmodule

`default_nettype wire

// ==== source/mold_skid_buffer.sv ====
// two-entry valid/ready register slice; ready is registered and payload is held unchanged while stalled
`default_nettype none
`timescale 1ns/1ps

module mold_skid_buffer #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     nreset,

	input  logic     in_v_i,
	input  payload_t in_data_i,
	output logic     in_ready_o,

	output logic     out_v_o,
	output payload_t out_data_o,
	input  logic     out_ready_i
);

	logic     out_v_q;
	logic     skid_v_q;
	payload_t out_q;
	payload_t skid_q;
	logic     out_free;

	// output slot empties this cycle or is already empty
	assign out_free = out_ready_i | ~out_v_q;

	// only the skid entry can block the input
	assign in_ready_o = ~skid_v_q;

	always_ff @(posedge clk) begin
		if (~nreset) begin
			out_v_q  <= 1'b0;
			skid_v_q <= 1'b0;
		end else if (out_free) begin
			// refill from the skid entry first to keep order
			out_v_q  <= skid_v_q | in_v_i;
			skid_v_q <= 1'b0;
		end else if (in_v_i & in_ready_o) begin
			skid_v_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			out_q <= skid_v_q ? skid_q : in_data_i;
		end
		if (~out_free & in_v_i & in_ready_o) begin
			skid_q <= in_data_i;
		end
	end

	assign out_v_o    = out_v_q;
	assign out_data_o = out_q;

endmodule

`default_nettype wire

// ==== source/mold_stream_pkg.sv ====
// stream beat types; byte 0 of a beat sits in data[7:0] and keep must be contiguous from lane 0
`default_nettype none

package mold_stream_pkg;

	localparam int unsigned BEAT_BYTES = 8;

	// 0 to BEAT_BYTES inclusive
	typedef logic [3:0] byte_cnt_t;

	// ingress beat as seen on the udp payload stream
	typedef struct packed {
		logic [BEAT_BYTES*8-1:0] data;
		logic [BEAT_BYTES-1:0]   keep;
		logic                    last;
	} axis_beat_t;

	// one chunk of a mold message, tagged with its session and sequence
	typedef struct packed {
		logic [BEAT_BYTES*8-1:0] data;
		logic [BEAT_BYTES-1:0]   mask;
		logic                    start;
		logic                    last;
		mold_proto_pkg::sid_t    sid;
		mold_proto_pkg::seq_t    seq;
	} msg_beat_t;

endpackage

`default_nettype wire

// ==== source/mold_proto_pkg.sv ====
// moldudp64 header layout and field types; all multi-byte fields are big-endian on the wire
`default_nettype none

package mold_proto_pkg;

	// header is session id, sequence number, message count back to back
	localparam int unsigned HDR_BYTES = 20;

	// every message block opens with a 2 byte big-endian length
	localparam int unsigned LEN_BYTES = 2;

	// message count value reserved for the end-of-session packet
	localparam logic [15:0] EOS_MSG_CNT = 16'hFFFF;

	// 10 byte session id, first header byte in the msb
	typedef logic [79:0] sid_t;

	// 8 byte sequence number of the first message in the packet
	typedef logic [63:0] seq_t;

	// shared by message length and message count fields
	typedef logic [15:0] msg_len_t;

endpackage

`default_nettype wire
